/* seg_display.f */
design/seg_pkg.sv
design/digit_source.sv
design/scan_sequencer.sv
design/segment_encoder.sv
design/seg_display.sv
testbench/seg_display_sva.sv
testbench/seg_display_checker.sv
testbench/seg_display_tb.sv

/* Makefile */
SIM      ?= verilator
FLAGS    ?= --binary --timing --assert -Wno-fatal
TOP      ?= seg_display_tb
FILELIST ?= seg_display.f
OBJ_DIR  ?= obj_dir

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"

test:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP) +verilator+error+limit+1000)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "TEST OK"

clean:
	rm -rf $(OBJ_DIR)

/* testbench/seg_display_tb.sv */
`timescale 1ns/100ps

module seg_display_tb;
    import seg_pkg::*;

    localparam int num_rows     = 14;
    localparam int reset_cycles = 4;
    localparam int scan_div     = 4;

    typedef struct {
        logic [word_w-1:0] data;
        logic              base;
        logic              en;
        int                dwell;
        logic              late;
        logic [word_w-1:0] late_data;
        logic [word_w-1:0] shown;
    } row_t;

    logic                  clk;
    logic                  rst;
    logic [word_w-1:0]     data;
    logic                  base;
    logic                  load;
    logic                  en;
    logic [num_digits-1:0] digit_en;
    logic [seg_w-1:0]      sseg;
    logic [seg_w-1:0]      sseg1;
    logic                  busy;
    logic [word_w-1:0]     model_value;
    logic                  model_base;
    row_t                  rows [num_rows];
    int                    tb_errors;

    seg_display #(
        .scan_div (scan_div)
    ) i_seg_display (
        .clk      (clk),
        .rst      (rst),
        .data     (data),
        .base     (base),
        .load     (load),
        .en       (en),
        .digit_en (digit_en),
        .sseg     (sseg),
        .sseg1    (sseg1),
        .busy     (busy)
    );

    seg_display_checker #(
        .scan_div (scan_div)
    ) i_seg_display_checker (
        .clk         (clk),
        .rst         (rst),
        .busy        (busy),
        .load        (load),
        .en          (en),
        .digit_en    (digit_en),
        .sseg        (sseg),
        .sseg1       (sseg1),
        .model_value (model_value),
        .model_base  (model_base)
    );

    always #4 clk = ~clk;

    task automatic set_row(input int r, input logic [word_w-1:0] d, input logic b,
                           input logic e, input int dwell, input logic late,
                           input logic [word_w-1:0] late_d, input logic [word_w-1:0] shown);
        rows[r].data      = d;
        rows[r].base      = b;
        rows[r].en        = e;
        rows[r].dwell     = dwell;
        rows[r].late      = late;
        rows[r].late_data = late_d;
        rows[r].shown     = shown;
    endtask

    // Columns are data, base, en, dwell, late load, late data and the value shown.
    task automatic fill_table();
        logic [word_w-1:0] random_word;
        set_row(0, 32'h0123_4567, 1'b0, 1'b1, 80, 1'b0, '0, 32'h0123_4567);
        set_row(1, 32'h89AB_CDEF, 1'b0, 1'b1, 80, 1'b0, '0, 32'h89AB_CDEF);
        set_row(2, 32'hDEAD_BEEF, 1'b0, 1'b0, 80, 1'b0, '0, 32'hDEAD_BEEF);
        set_row(3, 32'd0, 1'b1, 1'b1, 80, 1'b0, '0, 32'd0);
        set_row(4, 32'd9, 1'b1, 1'b1, 80, 1'b0, '0, 32'd9);
        set_row(5, 32'd10, 1'b1, 1'b1, 80, 1'b0, '0, 32'd10);
        set_row(6, 32'd1023, 1'b1, 1'b1, 80, 1'b0, '0, 32'd1023);
        set_row(7, 32'd99_999_999, 1'b1, 1'b1, 80, 1'b0, '0, 32'd99_999_999);
        set_row(8, 32'd123_456_789, 1'b1, 1'b1, 80, 1'b0, '0, 32'd123_456_789);
        // The second load lands mid-conversion and must be dropped.
        set_row(9, 32'd12_345_678, 1'b1, 1'b1, 88, 1'b1, 32'd87_654_321, 32'd12_345_678);
        set_row(10, 32'hFEDC_BA98, 1'b0, 1'b1, 80, 1'b0, '0, 32'hFEDC_BA98);
        for (int r = 11; r < num_rows; r++) begin
            random_word = $urandom();
            set_row(r, random_word, ($urandom() % 2) == 1, 1'b1, 96, 1'b0, '0, random_word);
        end
    endtask

    task automatic check_reset_state();
        int waited;
        waited = 0;
        if (digit_en !== '0 || sseg !== '0 || sseg1 !== '0 || busy !== 1'b0) begin
            tb_errors++;
            $display("ERROR at %0t: outputs not zero in reset, digit_en %b sseg %h sseg1 %h",
                     $time, digit_en, sseg, sseg1);
        end
        rst = 1'b0;
        en  = 1'b1;
        while (digit_en == '0 && waited < 20) begin
            @(negedge clk);
            waited++;
        end
        if (digit_en !== 8'h01 || sseg !== 8'h7E || sseg1 !== '0) begin
            tb_errors++;
            $display("ERROR at %0t: first lit digit is not digit 0 showing 0, got %b %h %h",
                     $time, digit_en, sseg, sseg1);
        end
    endtask

    task automatic apply_row(input int r);
        @(negedge clk);
        data = rows[r].data;
        base = rows[r].base;
        en   = rows[r].en;
        load = 1'b1;
        @(negedge clk);
        load = 1'b0;
        // A decimal load raises busy on the capture edge and a hex load leaves it low.
        if (busy !== rows[r].base) begin
            tb_errors++;
            $display("ERROR at %0t: busy is %b after a load with base %b",
                     $time, busy, rows[r].base);
        end
        if (rows[r].late) begin
            repeat (4) @(negedge clk);
            if (!busy) begin
                tb_errors++;
                $display("The conversion ended before the second load could be issued.");
            end
            data = rows[r].late_data;
            load = 1'b1;
            @(negedge clk);
            load = 1'b0;
        end
        while (busy) begin
            @(negedge clk);
        end
        model_value = rows[r].shown;
        model_base  = rows[r].base;
        repeat (rows[r].dwell) @(negedge clk);
    endtask

    initial begin
        int total;
        void'($urandom(96));
        clk         = 1'b0;
        rst         = 1'b1;
        data        = '0;
        base        = 1'b0;
        load        = 1'b0;
        en          = 1'b0;
        model_value = '0;
        model_base  = 1'b0;
        tb_errors   = 0;
        fill_table();
        repeat (reset_cycles) @(negedge clk);
        check_reset_state();
        for (int r = 0; r < num_rows; r++) begin
            apply_row(r);
        end
        if (i_seg_display_checker.check_count == 0) begin
            tb_errors++;
            $display("The checker compared no lit digits during the run.");
        end
        total = tb_errors + i_seg_display_checker.error_count
              + i_seg_display.i_segment_encoder.i_seg_display_sva.fail_count;
        $display("Errors: testbench %0d, checker %0d, assertions %0d, digits checked %0d",
                 tb_errors, i_seg_display_checker.error_count,
                 i_seg_display.i_segment_encoder.i_seg_display_sva.fail_count,
                 i_seg_display_checker.check_count);
        if (total == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

    // The limit allows each row its dwell plus the load and conversion time.
    initial begin
        int limit;
        @(negedge rst);
        limit = 40;
        for (int r = 0; r < num_rows; r++) begin
            limit += rows[r].dwell + 40;
        end
        repeat (limit) @(posedge clk);
        $display("Timeout: the run did not finish within %0d cycles after reset.", limit);
        $display("TEST FAILED");
        $finish;
    end

endmodule

/* testbench/seg_display_checker.sv */
`timescale 1ns/100ps

module seg_display_checker #(
    parameter int scan_div = seg_pkg::scan_div_default
) (
    input logic                           clk,
    input logic                           rst,
    input logic                           busy,
    input logic                           load,
    input logic                           en,
    input logic [seg_pkg::num_digits-1:0] digit_en,
    input logic [seg_pkg::seg_w-1:0]      sseg,
    input logic [seg_pkg::seg_w-1:0]      sseg1,
    input logic [seg_pkg::word_w-1:0]     model_value,
    input logic                           model_base
);
    import seg_pkg::*;

    logic [6:0]            seg_table [16];
    int                    error_count;
    int                    check_count;
    int                    hold;
    logic                  en_q;
    logic                  base_q;
    logic [word_w-1:0]     value_q;
    logic [num_digits-1:0] prev_en;
    int                    run_len;
    logic                  run_whole;
    int                    busy_len;

    // Segments a to g, a on the top bit.
    initial begin
        seg_table   = '{7'h7E, 7'h30, 7'h6D, 7'h79, 7'h33, 7'h5B, 7'h5F, 7'h70,
                        7'h7F, 7'h7B, 7'h77, 7'h1F, 7'h4E, 7'h3D, 7'h4F, 7'h47};
        error_count = 0;
        check_count = 0;
        hold        = 3;
        en_q        = 1'b0;
        base_q      = 1'b0;
        value_q     = '0;
        prev_en     = '0;
        run_len     = 0;
        run_whole   = 1'b0;
        busy_len    = 0;
    end

    function automatic int expected_digit(input logic [word_w-1:0] value, input logic dec,
                                          input int k);
        int unsigned v;
        v = value;
        if (dec) begin
            for (int i = 0; i < k; i++) begin
                v = v / 10;
            end
            return int'(v % 10);
        end
        return int'((value >> (4 * k)) & 32'hF);
    endfunction

    // A decimal conversion takes one shift per bit of the word.
    always @(posedge clk) begin
        if (busy) begin
            busy_len++;
        end else if (busy_len != 0) begin
            if (busy_len != word_w) begin
                error_count++;
                $display("ERROR at %0t: busy stayed high for %0d cycles, expected %0d",
                         $time, busy_len, word_w);
            end
            busy_len = 0;
        end
    end

    always @(posedge clk) begin
        int               k;
        logic [seg_w-1:0] exp_pat;
        logic [seg_w-1:0] exp_low;
        logic [seg_w-1:0] exp_high;
        k = 0;
        // The outputs trail any change of value, base or enable by a few edges.
        if (rst || busy || load || en != en_q || model_value != value_q
                || model_base != base_q) begin
            hold    = 3;
            prev_en = '0;
        end else if (hold != 0) begin
            hold    = hold - 1;
            prev_en = '0;
        end else if (!en) begin
            prev_en = '0;
            if (digit_en != '0 || sseg != '0 || sseg1 != '0) begin
                error_count++;
                $display("ERROR at %0t: display not dark with en low, digit_en %b sseg %h sseg1 %h",
                         $time, digit_en, sseg, sseg1);
            end
        end else if (!$onehot(digit_en)) begin
            prev_en = '0;
            error_count++;
            $display("ERROR at %0t: digit_en %b does not light exactly one digit",
                     $time, digit_en);
        end else begin
            for (int i = 0; i < num_digits; i++) begin
                if (digit_en[i]) begin
                    k = i;
                end
            end
            exp_pat  = {1'b0, seg_table[expected_digit(model_value, model_base, k)]};
            exp_low  = (k < 4) ? exp_pat : '0;
            exp_high = (k < 4) ? '0 : exp_pat;
            check_count++;
            if (sseg != exp_low || sseg1 != exp_high) begin
                error_count++;
                $display("ERROR at %0t: digit %0d expected sseg %h sseg1 %h, got %h %h",
                         $time, k, exp_low, exp_high, sseg, sseg1);
            end
            // Each digit stays lit for scan_div cycles and the scan runs 0 to 7.
            if (digit_en == prev_en) begin
                run_len++;
                if (run_len == scan_div + 1) begin
                    error_count++;
                    $display("ERROR at %0t: digit_en %b held longer than %0d cycles",
                             $time, digit_en, scan_div);
                end
            end else begin
                if (prev_en != '0
                        && (digit_en != {prev_en[num_digits-2:0], prev_en[num_digits-1]}
                        || (run_whole && run_len != scan_div))) begin
                    error_count++;
                    $display("ERROR at %0t: digit_en stepped from %b to %b after %0d cycles",
                             $time, prev_en, digit_en, run_len);
                end
                run_whole = (prev_en != '0);
                run_len   = 1;
                prev_en   = digit_en;
            end
        end
        en_q    = en;
        base_q  = model_base;
        value_q = model_value;
    end

endmodule

/* testbench/seg_display_sva.sv */
`timescale 1ns/100ps

module seg_display_sva (
    input logic                           clk,
    input logic                           rst,
    input logic [seg_pkg::num_digits-1:0] digit_en,
    input logic [seg_pkg::seg_w-1:0]      sseg,
    input logic [seg_pkg::seg_w-1:0]      sseg1
);
    int fail_count = 0;

    enable_onehot: assert property (@(posedge clk) disable iff (rst)
        $onehot0(digit_en))
    else begin
        fail_count++;
        $error("digit_en is neither zero nor one-hot");
    end

    one_bus_lit: assert property (@(posedge clk) disable iff (rst)
        !(sseg != '0 && sseg1 != '0))
    else begin
        fail_count++;
        $error("sseg and sseg1 are both driven at once");
    end

    point_dark: assert property (@(posedge clk) disable iff (rst)
        !sseg[7] && !sseg1[7])
    else begin
        fail_count++;
        $error("a decimal-point bit is set");
    end

    // A dark display must not drive any segment.
    dark_buses: assert property (@(posedge clk) disable iff (rst)
        digit_en == '0 |-> sseg == '0 && sseg1 == '0)
    else begin
        fail_count++;
        $error("segments are driven while no digit is enabled");
    end

endmodule

bind segment_encoder seg_display_sva i_seg_display_sva (
    .clk      (clk),
    .rst      (rst),
    .digit_en (digit_en),
    .sseg     (sseg),
    .sseg1    (sseg1)
);

/* design/seg_display.sv */
`timescale 1ns/100ps

module seg_display #(
    parameter int scan_div = seg_pkg::scan_div_default
) (
    input  logic                           clk,
    input  logic                           rst,
    input  logic [seg_pkg::word_w-1:0]     data,
    input  logic                           base,
    input  logic                           load,
    input  logic                           en,
    output logic [seg_pkg::num_digits-1:0] digit_en,
    output logic [seg_pkg::seg_w-1:0]      sseg,
    output logic [seg_pkg::seg_w-1:0]      sseg1,
    output logic                           busy
);
    import seg_pkg::*;

    display_word_t         shown_digits;
    logic [num_digits-1:0] scan_en;
    logic [digit_w-1:0]    scan_code;
    logic                  scan_upper;

    digit_source i_digit_source (
        .clk          (clk),
        .rst          (rst),
        .data         (data),
        .base         (base),
        .load         (load),
        .shown_digits (shown_digits),
        .busy         (busy)
    );

    scan_sequencer #(
        .scan_div (scan_div)
    ) i_scan_sequencer (
        .clk          (clk),
        .rst          (rst),
        .en           (en),
        .shown_digits (shown_digits),
        .scan_en      (scan_en),
        .scan_code    (scan_code),
        .scan_upper   (scan_upper)
    );

    segment_encoder i_segment_encoder (
        .clk        (clk),
        .rst        (rst),
        .scan_en    (scan_en),
        .scan_code  (scan_code),
        .scan_upper (scan_upper),
        .digit_en   (digit_en),
        .sseg       (sseg),
        .sseg1      (sseg1)
    );

endmodule

/* design/segment_encoder.sv */
`timescale 1ns/100ps

module segment_encoder (
    input  logic                           clk,
    input  logic                           rst,
    input  logic [seg_pkg::num_digits-1:0] scan_en,
    input  logic [seg_pkg::digit_w-1:0]    scan_code,
    input  logic                           scan_upper,
    output logic [seg_pkg::num_digits-1:0] digit_en,
    output logic [seg_pkg::seg_w-1:0]      sseg,
    output logic [seg_pkg::seg_w-1:0]      sseg1
);
    import seg_pkg::*;

    logic [seg_w-1:0] pattern;
    logic             lit;

    // The decimal point stays dark.
    assign pattern = {1'b0, seg_pattern(scan_code)};

    assign lit = |scan_en;

    // Enables and both buses leave on the same edge.
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            digit_en <= '0;
            sseg     <= '0;
            sseg1    <= '0;
        end else begin
            digit_en <= scan_en;
            if (lit && !scan_upper) begin
                sseg <= pattern;
            end else begin
                sseg <= '0;
            end
            if (lit && scan_upper) begin
                sseg1 <= pattern;
            end else begin
                sseg1 <= '0;
            end
        end
    end

endmodule

/* design/scan_sequencer.sv */
`timescale 1ns/100ps

module scan_sequencer #(
    parameter int scan_div = seg_pkg::scan_div_default
) (
    input  logic                           clk,
    input  logic                           rst,
    input  logic                           en,
    input  seg_pkg::display_word_t         shown_digits,
    output logic [seg_pkg::num_digits-1:0] scan_en,
    output logic [seg_pkg::digit_w-1:0]    scan_code,
    output logic                           scan_upper
);
    import seg_pkg::*;

    localparam int tick_w = (scan_div > 1) ? $clog2(scan_div) : 1;
    localparam int idx_w  = $clog2(num_digits);

    logic [tick_w-1:0] tick_cnt;
    logic              tick;
    logic [idx_w-1:0]  idx;

    assign tick = (tick_cnt == tick_w'(scan_div - 1));

    // One scan step every scan_div cycles.
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            tick_cnt <= '0;
            idx      <= '0;
        end else if (tick) begin
            tick_cnt <= '0;
            if (idx == idx_w'(num_digits - 1)) begin
                idx <= '0;
            end else begin
                idx <= idx + 1'b1;
            end
        end else begin
            tick_cnt <= tick_cnt + 1'b1;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            scan_en    <= '0;
            scan_code  <= '0;
            scan_upper <= 1'b0;
        end else begin
            if (en) begin
                scan_en <= num_digits'(1) << idx;
            end else begin
                scan_en <= '0;
            end
            scan_code  <= shown_digits.digits[idx];
            // Digits 4 to 7 go out on the second segment bus.
            scan_upper <= (idx >= idx_w'(num_digits / 2));
        end
    end

endmodule

/* design/digit_source.sv */
`timescale 1ns/100ps

module digit_source (
    input  logic                       clk,
    input  logic                       rst,
    input  logic [seg_pkg::word_w-1:0] data,
    input  logic                       base,
    input  logic                       load,
    output seg_pkg::display_word_t     shown_digits,
    output logic                       busy
);
    import seg_pkg::*;

    localparam int cnt_w = $clog2(word_w);

    display_word_t                      load_word;
    logic                               accept;
    logic                               last_shift;
    logic [cnt_w-1:0]                   shift_cnt;
    logic [word_w-1:0]                  bin_reg;
    logic [num_digits-1:0][digit_w-1:0] bcd_reg;
    logic [num_digits-1:0][digit_w-1:0] bcd_adj;
    logic [word_w-1:0]                  bcd_flat;
    logic [word_w-1:0]                  bcd_next;

    assign load_word.value = data;

    // A load is only taken while no conversion is running.
    assign accept = load & ~busy;

    assign last_shift = (shift_cnt == cnt_w'(word_w - 1));

    // Add three to every BCD nibble of five or more before the shift.
    always_comb begin
        for (int i = 0; i < num_digits; i++) begin
            if (bcd_reg[i] >= digit_w'(5)) begin
                bcd_adj[i] = bcd_reg[i] + digit_w'(3);
            end else begin
                bcd_adj[i] = bcd_reg[i];
            end
        end
    end

    assign bcd_flat = bcd_adj;

    // The top BCD bit falls off, which keeps the value modulo 10^8.
    assign bcd_next = {bcd_flat[word_w-2:0], bin_reg[word_w-1]};

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            busy         <= 1'b0;
            shift_cnt    <= '0;
            shown_digits <= '0;
        end else if (accept) begin
            shift_cnt <= '0;
            if (base) begin
                busy <= 1'b1;
            end else begin
                shown_digits.digits <= load_word.digits;
            end
        end else if (busy) begin
            shift_cnt <= shift_cnt + 1'b1;
            // The last shift result goes straight to the display.
            if (last_shift) begin
                busy                <= 1'b0;
                shown_digits.digits <= bcd_next;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            bin_reg <= load_word.value;
            bcd_reg <= '0;
        end else if (busy) begin
            bin_reg <= bin_reg << 1;
            bcd_reg <= bcd_next;
        end
    end

endmodule

/* design/seg_pkg.sv */
package seg_pkg;

    localparam int num_digits       = 8;
    localparam int digit_w          = 4;
    localparam int word_w           = 32;
    localparam int seg_w            = 8;
    localparam int scan_div_default = 50000;

    // The same captured word is read as a binary number by the BCD converter
    // and as eight nibbles by the hex path and the scan mux.
    typedef union packed {
        logic [word_w-1:0]                  value;
        logic [num_digits-1:0][digit_w-1:0] digits;
    } display_word_t;

    // Segments a to g sit on bits 6 down to 0.
    function automatic logic [6:0] seg_pattern(input logic [digit_w-1:0] code);
        logic [6:0] pat;
        case (code)
            4'h0: pat = 7'b1111110;
            4'h1: pat = 7'b0110000;
            4'h2: pat = 7'b1101101;
            4'h3: pat = 7'b1111001;
            4'h4: pat = 7'b0110011;
            4'h5: pat = 7'b1011011;
            4'h6: pat = 7'b1011111;
            4'h7: pat = 7'b1110000;
            4'h8: pat = 7'b1111111;
            4'h9: pat = 7'b1111011;
            4'hA: pat = 7'b1110111;
            4'hB: pat = 7'b0011111;
            4'hC: pat = 7'b1001110;
            4'hD: pat = 7'b0111101;
            4'hE: pat = 7'b1001111;
            default: pat = 7'b1000111;
        endcase
        return pat;
    endfunction

endpackage
